/* sim.f */
fix_pkg.sv
fix_parser.sv
rx_checksum.sv
msg_processor.sv
session_manager.sv
msg_builder.sv
fix_engine.sv
tb_fix_engine.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_fix_engine -f sim.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* tb_fix_engine.sv */
`timescale 1ns/1ns

module tb_fix_engine;

	localparam int NUM_HOST    = 4;
	localparam int HOST_W      = 2;
	localparam int REPLY_LIMIT = 400;     // one reply with stalls and the digit conversion
	localparam int RUN_LIMIT   = 20000;   // all tests together take about 1600 cycles

	logic                clk = 1'b0;
	logic                rst_i;
	logic                rx_valid_i;
	logic [7:0]          rx_data_i;
	logic [HOST_W-1:0]   rx_host_i;
	logic                connect_i;
	logic [HOST_W-1:0]   connect_to_host_i;
	logic                fifo_full_i;
	logic                fifo_write_o;
	logic [7:0]          message_o;
	logic                end_o;
	logic [NUM_HOST-1:0] logged_on_o;

	logic [7:0]  txt_q [$];   // scratch bytes from text_to_bytes
	logic [7:0]  exp_q [$];   // expected reply
	logic [7:0]  rx_q  [$];   // inbound message to drive
	logic [7:0]  got_q [$];   // bytes written by the DUT
	int          txt_sum    = 0;
	int          write_cnt  = 0;
	int          done_cnt   = 0;
	int          errors     = 0;
	int          tests_ok   = 0;
	int          tests_bad  = 0;
	int          cycles     = 0;
	int          stall_hits = 0;
	int          exp_seq [NUM_HOST];
	logic [31:0] lcg_state  = 32'd51453;

	fix_engine #(
		.NUM_HOST (NUM_HOST),
		.HOST_W   (HOST_W)
	) i_dut (
		.clk               (clk),
		.rst_i             (rst_i),
		.rx_valid_i        (rx_valid_i),
		.rx_data_i         (rx_data_i),
		.rx_host_i         (rx_host_i),
		.connect_i         (connect_i),
		.connect_to_host_i (connect_to_host_i),
		.fifo_full_i       (fifo_full_i),
		.fifo_write_o      (fifo_write_o),
		.message_o         (message_o),
		.end_o             (end_o),
		.logged_on_o       (logged_on_o)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// sample mid-cycle, away from the drive edge
	always @(negedge clk) begin
		if (!rst_i) begin
			if (fifo_full_i && got_q.size() != 0)
				stall_hits++;   // full while a reply is under way
			if (fifo_write_o) begin
				got_q.push_back(message_o);
				write_cnt++;
			end
			if (end_o)
				done_cnt++;
			if (fifo_write_o && fifo_full_i) begin
				$display("ERROR %0t: write while the FIFO reports full", $time);
				errors++;
			end
			if (end_o && !fifo_write_o) begin
				$display("ERROR %0t: end_o without a write", $time);
				errors++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= RUN_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// '|' in the text stands for the SOH separator
	task automatic text_to_bytes(input string s);
		logic [7:0] b;
		txt_q.delete();
		txt_sum = 0;
		for (int i = 0; i < s.len(); i++) begin
			b = (s[i] == "|") ? 8'h01 : s[i];
			txt_q.push_back(b);
			txt_sum = txt_sum + int'(b);
		end
	endtask

	task automatic build_reply(input string mtype, input int host);
		string body;
		int    cks;
		body = $sformatf("8=FIX.4.2|35=%s|34=%03d|49=ENG|56=H%0d|", mtype, exp_seq[host], host);
		text_to_bytes(body);
		cks = txt_sum % 256;
		text_to_bytes({body, $sformatf("10=%03d|", cks)});
		exp_q = txt_q;
		exp_seq[host] = (exp_seq[host] + 1) % 1000;   // every send moves the host counter
	endtask

	task automatic build_inbound(input string mtype, input int host, input bit bad_cks);
		string body;
		int    cks;
		body = $sformatf("8=FIX.4.2|35=%s|49=H%0d|56=ENG|", mtype, host);
		text_to_bytes(body);
		cks = (txt_sum + (bad_cks ? 7 : 0)) % 256;
		text_to_bytes({body, $sformatf("10=%03d|", cks)});
		rx_q = txt_q;
	endtask

	task automatic send_inbound(input int host);
		foreach (rx_q[i]) begin
			@(posedge clk);
			rx_valid_i <= 1'b1;
			rx_data_i  <= rx_q[i];
			rx_host_i  <= 2'(host);   // steady for the whole message
		end
		@(posedge clk);
		rx_valid_i <= 1'b0;
	endtask

	task automatic wait_reply(input bit stall);
		int start;
		int n;
		bit ok;
		start = done_cnt;
		n     = 0;
		ok    = 1'b0;
		while (!ok && n < REPLY_LIMIT) begin
			@(posedge clk);
			if (stall) begin
				lcg_state = lcg_step(lcg_state);
				fifo_full_i <= (lcg_state[18:16] < 3'd3);
			end
			if (done_cnt != start)
				ok = 1'b1;
			n++;
		end
		fifo_full_i <= 1'b0;
		if (!ok) begin
			$display("no reply came within %0d cycles", REPLY_LIMIT);
			errors++;
		end
	endtask

	task automatic compare_reply(input string what);
		bit bad;
		bad = 1'b0;
		if (got_q.size() != exp_q.size()) begin
			$display("ERROR %0t: %s reply has %0d bytes, expected %0d", $time, what,
				got_q.size(), exp_q.size());
			errors++;
		end else begin
			foreach (exp_q[i]) begin
				if (!bad && got_q[i] != exp_q[i]) begin
					$display("ERROR %0t: %s reply byte %0d is %h, expected %h", $time, what,
						i, got_q[i], exp_q[i]);
					errors++;
					bad = 1'b1;
				end
			end
		end
		got_q.delete();
	endtask

	task automatic expect_silence(input int n, input string what);
		int start;
		start = write_cnt;
		repeat (n) @(posedge clk);
		if (write_cnt != start) begin
			$display("ERROR %0t: %s caused %0d writes, expected none", $time, what,
				write_cnt - start);
			errors++;
			got_q.delete();
		end
	endtask

	task automatic expect_logged(input logic [NUM_HOST-1:0] exp, input string what);
		if (logged_on_o != exp) begin
			$display("ERROR %0t: logged_on_o is %b after %s, expected %b", $time,
				logged_on_o, what, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", name, errors - err_start);
			tests_bad++;
		end
	endtask

	task automatic check_reset_idle();
		int e;
		int d;
		e = errors;
		d = done_cnt;
		expect_silence(50, "idle inputs");
		if (done_cnt != d) begin
			$display("ERROR %0t: end_o pulsed with idle inputs", $time);
			errors++;
		end
		expect_logged(4'b0000, "reset");
		finish_test("reset idle", e);
	endtask

	task automatic logon_heartbeat();
		int e;
		e = errors;
		build_inbound("A", 2, 1'b0);
		send_inbound(2);
		build_reply("A", 2);
		wait_reply(1'b0);
		compare_reply("logon");
		expect_logged(4'b0100, "logon from host 2");
		build_inbound("0", 2, 1'b0);
		send_inbound(2);
		build_reply("0", 2);
		wait_reply(1'b0);
		compare_reply("heartbeat");
		finish_test("logon and heartbeat", e);
	endtask

	task automatic bad_checksum_ignored();
		int e;
		e = errors;
		build_inbound("0", 2, 1'b1);
		send_inbound(2);
		expect_silence(200, "bad checksum heartbeat");
		expect_logged(4'b0100, "bad checksum heartbeat");
		build_inbound("0", 3, 1'b0);   // host 3 never logged on
		send_inbound(3);
		expect_silence(200, "heartbeat from idle host");
		expect_logged(4'b0100, "heartbeat from idle host");
		finish_test("ignored messages", e);
	endtask

	task automatic connect_logon();
		int e;
		e = errors;
		@(posedge clk);
		connect_i         <= 1'b1;
		connect_to_host_i <= 2'd1;
		@(posedge clk);
		connect_i <= 1'b0;
		build_reply("A", 1);
		wait_reply(1'b0);
		compare_reply("connect logon");
		expect_logged(4'b0100, "connect to host 1");
		build_inbound("A", 1, 1'b0);
		send_inbound(1);
		expect_silence(200, "logon answer from host 1");
		expect_logged(4'b0110, "logon answer from host 1");
		finish_test("application connect", e);
	endtask

	task automatic stalled_reply();
		int e;
		e = errors;
		stall_hits = 0;
		build_inbound("0", 1, 1'b0);
		send_inbound(1);
		build_reply("0", 1);
		wait_reply(1'b1);
		compare_reply("stalled heartbeat");
		if (stall_hits == 0) begin
			$display("the FIFO was never full during the stalled reply");
			errors++;
		end
		finish_test("reply under back-pressure", e);
	endtask

	task automatic logout_reply();
		int e;
		e = errors;
		build_inbound("5", 2, 1'b0);
		send_inbound(2);
		build_reply("5", 2);
		wait_reply(1'b0);
		compare_reply("logout");
		expect_logged(4'b0010, "logout from host 2");
		finish_test("logout", e);
	endtask

	initial begin
		rst_i             = 1'b1;
		rx_valid_i        = 1'b0;
		rx_data_i         = 8'h00;
		rx_host_i         = '0;
		connect_i         = 1'b0;
		connect_to_host_i = '0;
		fifo_full_i       = 1'b0;
		for (int i = 0; i < NUM_HOST; i++)
			exp_seq[i] = 1;
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;
		check_reset_idle();
		logon_heartbeat();
		bad_checksum_ignored();
		connect_logon();
		stalled_reply();
		logout_reply();
		repeat (10) @(posedge clk);
		$display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* fix_engine.sv */
`timescale 1ns/1ns

module fix_engine #(
	parameter int NUM_HOST = 4,
	parameter int HOST_W   = 2
) (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                rx_valid_i,
	input  logic [7:0]          rx_data_i,
	input  logic [HOST_W-1:0]   rx_host_i,
	input  logic                connect_i,
	input  logic [HOST_W-1:0]   connect_to_host_i,
	input  logic                fifo_full_i,
	output logic                fifo_write_o,
	output logic [7:0]          message_o,
	output logic                end_o,
	output logic [NUM_HOST-1:0] logged_on_o
);

	fix_pkg::field_t    field;
	logic               field_valid;
	logic               byte_valid;
	logic [7:0]         byte_data;
	logic               trailer;
	logic               sum_ok;
	logic               msg_valid;
	fix_pkg::msg_info_t msg;
	logic               tx_start;
	fix_pkg::tx_req_t   tx_req;
	logic               busy;
	logic [3:0]         rx_host_ext;   // struct host fields are four bits

	assign rx_host_ext = 4'(rx_host_i);

	fix_parser i_parser (
		.clk           (clk),
		.rst_i         (rst_i),
		.rx_valid_i    (rx_valid_i),
		.rx_data_i     (rx_data_i),
		.field_valid_o (field_valid),
		.field_o       (field),
		.byte_valid_o  (byte_valid),
		.byte_data_o   (byte_data),
		.trailer_o     (trailer)
	);

	rx_checksum i_rx_checksum (
		.clk           (clk),
		.rst_i         (rst_i),
		.byte_valid_i  (byte_valid),
		.byte_data_i   (byte_data),
		.trailer_i     (trailer),
		.field_valid_i (field_valid),
		.field_i       (field),
		.sum_ok_o      (sum_ok)
	);

	msg_processor i_msg_processor (
		.clk           (clk),
		.rst_i         (rst_i),
		.rx_host_i     (rx_host_ext),
		.field_valid_i (field_valid),
		.field_i       (field),
		.sum_ok_i      (sum_ok),
		.msg_valid_o   (msg_valid),
		.msg_o         (msg)
	);

	session_manager #(
		.NUM_HOST (NUM_HOST),
		.HOST_W   (HOST_W)
	) i_session_manager (
		.clk               (clk),
		.rst_i             (rst_i),
		.msg_valid_i       (msg_valid),
		.msg_i             (msg),
		.connect_i         (connect_i),
		.connect_to_host_i (connect_to_host_i),
		.busy_i            (busy),
		.tx_start_o        (tx_start),
		.tx_req_o          (tx_req),
		.logged_on_o       (logged_on_o)
	);

	msg_builder i_msg_builder (
		.clk          (clk),
		.rst_i        (rst_i),
		.tx_start_i   (tx_start),
		.tx_req_i     (tx_req),
		.fifo_full_i  (fifo_full_i),
		.busy_o       (busy),
		.fifo_write_o (fifo_write_o),
		.message_o    (message_o),
		.end_o        (end_o)
	);

endmodule

/* msg_builder.sv */
`timescale 1ns/1ns

module msg_builder (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             tx_start_i,
	input  fix_pkg::tx_req_t tx_req_i,
	input  logic             fifo_full_i,
	output logic             busy_o,
	output logic             fifo_write_o,
	output logic [7:0]       message_o,
	output logic             end_o
);

	localparam logic [5:0] POS_TRAILER = 6'd35;   // first byte of "10="
	localparam logic [5:0] POS_LAST    = 6'd41;

	typedef enum logic [1:0] {
		B_IDLE,
		B_SEND,
		B_CONV
	} phase_t;

	phase_t           phase_q;
	logic [5:0]       pos_q;
	fix_pkg::tx_req_t req_q;
	logic [7:0]       cks_q;     // running sum, later the remainder
	logic [3:0]       hund_q;
	logic [3:0]       tens_q;
	logic [7:0]       cur_byte;
	logic [7:0]       cks_next;

	assign busy_o       = (phase_q != B_IDLE);
	assign fifo_write_o = (phase_q == B_SEND) && !fifo_full_i;
	assign end_o        = fifo_write_o && (pos_q == POS_LAST);
	assign message_o    = cur_byte;
	assign cks_next     = cks_q + cur_byte;

	always_comb begin
		case (pos_q)
			6'd0:                                    cur_byte = "8";
			6'd1, 6'd12, 6'd17, 6'd24, 6'd31, 6'd37: cur_byte = "=";
			6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd8:
				cur_byte = fix_pkg::BEGIN_STR[8 * (8 - int'(pos_q)) +: 8];
			6'd9, 6'd14, 6'd21, 6'd28, 6'd34, 6'd41: cur_byte = fix_pkg::SOH;
			6'd10, 6'd15:                            cur_byte = "3";
			6'd11, 6'd29:                            cur_byte = "5";
			6'd13:                                   cur_byte = req_q.msg_type;
			6'd16, 6'd22:                            cur_byte = "4";
			6'd18:                                   cur_byte = {4'h3, req_q.seq[11:8]};
			6'd19:                                   cur_byte = {4'h3, req_q.seq[7:4]};
			6'd20:                                   cur_byte = {4'h3, req_q.seq[3:0]};
			6'd23:                                   cur_byte = "9";
			6'd25, 6'd26, 6'd27:
				cur_byte = fix_pkg::SENDER_ID[8 * (27 - int'(pos_q)) +: 8];
			6'd30:                                   cur_byte = "6";
			6'd32:                                   cur_byte = "H";
			6'd33:                                   cur_byte = {4'h3, req_q.host};  // hosts 0 to 9
			6'd35:                                   cur_byte = "1";
			6'd36:                                   cur_byte = "0";
			6'd38:                                   cur_byte = {4'h3, hund_q};
			6'd39:                                   cur_byte = {4'h3, tens_q};
			6'd40:                                   cur_byte = {4'h3, cks_q[3:0]};
			default:                                 cur_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			phase_q <= B_IDLE;
			pos_q   <= '0;
			cks_q   <= '0;
			hund_q  <= '0;
			tens_q  <= '0;
		end else begin
			case (phase_q)
				B_IDLE: begin
					if (tx_start_i) begin
						phase_q <= B_SEND;
						pos_q   <= '0;
						cks_q   <= '0;
					end
				end
				B_SEND: begin
					if (!fifo_full_i) begin   // byte goes out this cycle
						pos_q <= pos_q + 6'd1;
						if (pos_q < POS_TRAILER)
							cks_q <= cks_next;
						if (pos_q == POS_TRAILER - 6'd1) begin
							phase_q <= B_CONV;
							hund_q  <= '0;
							tens_q  <= '0;
						end
						if (pos_q == POS_LAST)
							phase_q <= B_IDLE;
					end
				end
				B_CONV: begin
					if (cks_q >= 8'd100) begin
						cks_q  <= cks_q - 8'd100;
						hund_q <= hund_q + 4'd1;
					end else if (cks_q >= 8'd10) begin
						cks_q  <= cks_q - 8'd10;
						tens_q <= tens_q + 4'd1;
					end else begin
						phase_q <= B_SEND;    // ones digit is what is left
					end
				end
				default: phase_q <= B_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase_q == B_IDLE && tx_start_i)
			req_q <= tx_req_i;
	end

	// trailer digits leave the conversion as decimal characters
	assert property (@(posedge clk) disable iff (rst_i)
		(fifo_write_o && pos_q > 6'd37 && pos_q < POS_LAST) |->
			(cur_byte >= "0" && cur_byte <= "9"));

endmodule

/* session_manager.sv */
`timescale 1ns/1ns

module session_manager #(
	parameter int NUM_HOST = 4,
	parameter int HOST_W   = 2
) (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 msg_valid_i,
	input  fix_pkg::msg_info_t   msg_i,
	input  logic                 connect_i,
	input  logic [HOST_W-1:0]    connect_to_host_i,
	input  logic                 busy_i,
	output logic                 tx_start_o,
	output fix_pkg::tx_req_t     tx_req_o,
	output logic [NUM_HOST-1:0]  logged_on_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOGON_SENT,
		S_ACTIVE
	} sess_t;

	sess_t             state_q [NUM_HOST];
	fix_pkg::seq_bcd_t seq_q   [NUM_HOST];   // next outgoing seq per host
	logic              pend_q;
	fix_pkg::tx_req_t  pend_req_q;
	logic              rx_hit;
	logic              upd;
	logic              send;
	logic [HOST_W-1:0] upd_host;
	sess_t             upd_state;
	logic [7:0]        send_type;
	fix_pkg::tx_req_t  new_req;
	logic              issue_ok;

	function automatic fix_pkg::seq_bcd_t bcd_inc(input fix_pkg::seq_bcd_t s);
		logic [3:0] d0;
		logic [3:0] d1;
		logic [3:0] d2;
		d0 = s[3:0];
		d1 = s[7:4];
		d2 = s[11:8];
		if (d0 != 4'd9) begin
			d0 = d0 + 4'd1;
		end else begin
			d0 = 4'd0;
			if (d1 != 4'd9) begin
				d1 = d1 + 4'd1;
			end else begin
				d1 = 4'd0;
				d2 = (d2 != 4'd9) ? d2 + 4'd1 : 4'd0;   // 999 wraps to 000
			end
		end
		return {d2, d1, d0};
	endfunction

	// connect wins a tie with an inbound message
	assign rx_hit   = msg_valid_i && msg_i.checksum_ok && (32'(msg_i.host) < NUM_HOST) && !connect_i;
	assign issue_ok = !busy_i && !tx_start_o;   // builder raises busy a cycle late

	always_comb begin
		upd       = 1'b0;
		send      = 1'b0;
		upd_state = S_IDLE;
		send_type = fix_pkg::MT_LOGON;
		upd_host  = connect_i ? connect_to_host_i : HOST_W'(msg_i.host);
		if (connect_i) begin
			upd       = 1'b1;
			send      = 1'b1;
			upd_state = S_LOGON_SENT;
		end else if (rx_hit) begin
			case (state_q[upd_host])
				S_IDLE: begin
					if (msg_i.msg_type == fix_pkg::MT_LOGON) begin
						upd       = 1'b1;
						send      = 1'b1;
						upd_state = S_ACTIVE;
					end
				end
				S_LOGON_SENT: begin
					if (msg_i.msg_type == fix_pkg::MT_LOGON) begin
						upd       = 1'b1;   // our logon got answered
						upd_state = S_ACTIVE;
					end
				end
				S_ACTIVE: begin
					if (msg_i.msg_type == fix_pkg::MT_HEARTBEAT) begin
						send      = 1'b1;
						send_type = fix_pkg::MT_HEARTBEAT;
					end else if (msg_i.msg_type == fix_pkg::MT_LOGOUT) begin
						upd       = 1'b1;
						send      = 1'b1;
						upd_state = S_IDLE;
						send_type = fix_pkg::MT_LOGOUT;
					end
				end
				default: ;
			endcase
		end
		new_req = '{host: 4'(upd_host), msg_type: send_type, seq: seq_q[upd_host]};
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_HOST; i++) begin
				state_q[i] <= S_IDLE;
				seq_q[i]   <= 12'h001;
			end
			pend_q     <= 1'b0;
			tx_start_o <= 1'b0;
		end else begin
			if (upd)
				state_q[upd_host] <= upd_state;
			if (send)
				seq_q[upd_host] <= bcd_inc(seq_q[upd_host]);
			tx_start_o <= 1'b0;
			if (pend_q && issue_ok) begin
				tx_start_o <= 1'b1;
				pend_q     <= send;      // a fresh request takes the slot
			end else if (send && issue_ok) begin
				tx_start_o <= 1'b1;
			end else if (send) begin
				pend_q <= 1'b1;          // a second waiting request is lost
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pend_q && issue_ok) begin
			tx_req_o   <= pend_req_q;
			pend_req_q <= new_req;
		end else if (send && issue_ok) begin
			tx_req_o <= new_req;
		end else if (send && !pend_q) begin
			pend_req_q <= new_req;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_HOST; i++)
			logged_on_o[i] = (state_q[i] == S_ACTIVE);
	end

	// never start the builder while it is still sending
	assert property (@(posedge clk) disable iff (rst_i) tx_start_o |-> !busy_i);

endmodule

/* msg_processor.sv */
`timescale 1ns/1ns

module msg_processor (
	input  logic               clk,
	input  logic               rst_i,
	input  logic [3:0]         rx_host_i,
	input  logic               field_valid_i,
	input  fix_pkg::field_t    field_i,
	input  logic               sum_ok_i,
	output logic               msg_valid_o,
	output fix_pkg::msg_info_t msg_o
);

	logic [7:0] type_q;
	logic [3:0] host_q;     // sampled inside the message
	logic       cks_field;
	logic       type_field;

	assign cks_field  = field_valid_i && (field_i.tag == fix_pkg::TAG_CHECKSUM);
	assign type_field = field_valid_i && (field_i.tag == fix_pkg::TAG_MSGTYPE);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			type_q      <= 8'h00;
			msg_valid_o <= 1'b0;
		end else begin
			msg_valid_o <= cks_field;
			if (cks_field)
				type_q <= 8'h00;    // no 35= in the next one reads as zero
			else if (type_field)
				type_q <= field_i.val_char;
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid_i && !cks_field)
			host_q <= rx_host_i;
		if (cks_field)
			msg_o <= '{host: host_q, msg_type: type_q, checksum_ok: sum_ok_i};
	end

endmodule

/* rx_checksum.sv */
`timescale 1ns/1ns

module rx_checksum (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            byte_valid_i,
	input  logic [7:0]      byte_data_i,
	input  logic            trailer_i,
	input  logic            field_valid_i,
	input  fix_pkg::field_t field_i,
	output logic            sum_ok_o
);

	logic [7:0] sum_q;        // all bytes of the current message
	logic [7:0] field_sum_q;  // sum up to the last separator
	logic [7:0] total_q;      // frozen when 10= shows up
	logic [7:0] sum_next;
	logic       cks_field;

	assign sum_next  = sum_q + byte_data_i;
	assign cks_field = field_valid_i && (field_i.tag == fix_pkg::TAG_CHECKSUM);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			sum_q       <= '0;
			field_sum_q <= '0;
			total_q     <= '0;
		end else begin
			if (cks_field) begin
				sum_q       <= '0;      // next message starts clean
				field_sum_q <= '0;
			end else if (byte_valid_i) begin
				sum_q <= sum_next;
				if (byte_data_i == fix_pkg::SOH)
					field_sum_q <= sum_next;
			end
			if (trailer_i)
				total_q <= field_sum_q;   // drops the "10=" bytes
		end
	end

	// holds from the checksum field report until the next field
	assign sum_ok_o = (field_i.val_num == {2'b00, total_q});

endmodule

/* fix_parser.sv */
`timescale 1ns/1ns

module fix_parser (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            rx_valid_i,
	input  logic [7:0]      rx_data_i,
	output logic            field_valid_o,
	output fix_pkg::field_t field_o,
	output logic            byte_valid_o,
	output logic [7:0]      byte_data_o,
	output logic            trailer_o
);

	typedef enum logic {
		ST_TAG,
		ST_VAL
	} state_t;

	state_t     state_q;
	logic [9:0] tag_q;
	logic       tag_seen_q;   // at least one tag digit
	logic [7:0] val_char_q;
	logic [9:0] val_q;
	logic [1:0] val_len_q;    // digits taken so far
	logic       first_q;      // next byte opens the value
	logic       is_digit;
	logic [3:0] digit;

	assign is_digit = (rx_data_i >= "0") && (rx_data_i <= "9");
	assign digit    = 4'(rx_data_i - "0");

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q       <= ST_TAG;
			tag_q         <= '0;
			tag_seen_q    <= 1'b0;
			val_q         <= '0;
			val_len_q     <= '0;
			first_q       <= 1'b0;
			field_valid_o <= 1'b0;
			trailer_o     <= 1'b0;
			byte_valid_o  <= 1'b0;
		end else begin
			field_valid_o <= 1'b0;
			trailer_o     <= 1'b0;
			byte_valid_o  <= rx_valid_i;    // every byte goes on to the checksum
			if (rx_valid_i) begin
				case (state_q)
					ST_TAG: begin
						if (rx_data_i == "=") begin
							state_q   <= ST_VAL;
							val_q     <= '0;
							val_len_q <= '0;
							first_q   <= 1'b1;
							trailer_o <= (tag_q == fix_pkg::TAG_CHECKSUM);
						end else if (rx_data_i == fix_pkg::SOH) begin
							tag_q      <= '0;   // stray separator
							tag_seen_q <= 1'b0;
						end else if (is_digit) begin
							tag_q      <= (tag_q << 3) + (tag_q << 1) + 10'(digit);
							tag_seen_q <= 1'b1;
						end
					end
					ST_VAL: begin
						first_q <= 1'b0;
						if (rx_data_i == fix_pkg::SOH) begin
							field_valid_o <= 1'b1;
							state_q       <= ST_TAG;
							tag_q         <= '0;
							tag_seen_q    <= 1'b0;
						end else if (is_digit && val_len_q != 2'd3) begin
							val_q     <= (val_q << 3) + (val_q << 1) + 10'(digit);
							val_len_q <= val_len_q + 2'd1;
						end
					end
					default: state_q <= ST_TAG;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		byte_data_o <= rx_data_i;
		if (rx_valid_i && state_q == ST_TAG && rx_data_i == "=") begin
			val_char_q <= 8'h00;    // empty value reads as zero
		end else if (rx_valid_i && state_q == ST_VAL) begin
			if (rx_data_i == fix_pkg::SOH) begin
				field_o <= '{tag: tag_q, val_char: val_char_q, val_num: val_q};
			end else if (first_q) begin
				val_char_q <= rx_data_i;
			end
		end
	end

	// a value is only ever opened by a tag that had digits
	assert property (@(posedge clk) disable iff (rst_i)
		(rx_valid_i && rx_data_i == "=" && state_q == ST_VAL) |-> tag_seen_q);

endmodule

/* fix_pkg.sv */
package fix_pkg;

	localparam logic [7:0]  SOH       = 8'h01;
	localparam logic [55:0] BEGIN_STR = "FIX.4.2";
	localparam logic [23:0] SENDER_ID = "ENG";

	localparam logic [7:0] MT_LOGON     = "A";
	localparam logic [7:0] MT_HEARTBEAT = "0";
	localparam logic [7:0] MT_LOGOUT    = "5";

	localparam logic [9:0] TAG_MSGTYPE  = 10'd35;
	localparam logic [9:0] TAG_CHECKSUM = 10'd10;

	// three bcd digits, hundreds in the top nibble
	typedef logic [11:0] seq_bcd_t;

	typedef struct packed {
		logic [9:0] tag;       // decimal tag number
		logic [7:0] val_char;  // first value byte
		logic [9:0] val_num;   // up to three value digits
	} field_t;

	typedef struct packed {
		logic [3:0] host;
		logic [7:0] msg_type;     // zero when no 35= field came
		logic       checksum_ok;
	} msg_info_t;

	typedef struct packed {
		logic [3:0] host;
		logic [7:0] msg_type;
		seq_bcd_t   seq;
	} tx_req_t;

endpackage
